/* hw/axi_pkg.sv */
package axi_pkg;

    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;

    // size code for a 4-byte beat
    localparam logic [2:0] size_word = 3'b010;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } r_t;

endpackage

/* hw/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_valid,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  decode_ready,
    output logic                  fetch_valid,
    output fetch_pkg::fetch_pkt_t fetch_pkt,
    output logic [31:0]           lookup_addr,
    input  logic                  hit,
    input  logic [31:0]           hit_word,
    output logic                  fill_valid,
    output logic [31:0]           fill_addr,
    output fetch_pkg::block_t     fill_data,
    output logic                  ar_valid,
    output axi_pkg::ar_t          ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  axi_pkg::r_t           r,
    output logic                  r_ready
);
    import fetch_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        st_lookup,
        st_addr,
        st_data,
        st_install
    } state_t;

    state_t state;

    logic [31:0] pc;
    logic        pend_valid;
    logic [31:0] pend_target;

    block_t blk;
    logic   blk_fault;
    logic   blk_sdram;
    logic [$clog2(block_words)-1:0] beat;

    logic out_free;
    logic r_fire;
    logic last_beat;
    logic take_hit;
    logic start_miss;
    logic deliver_fault;
    logic [31:0] miss_base;

    function automatic logic in_sdram(input logic [31:0] addr);
        return (addr[31:28] == sdram_hi_lo) || (addr[31:28] == sdram_hi_hi);
    endfunction

    assign out_free  = !fetch_valid || decode_ready;
    assign r_fire    = r_valid && r_ready;
    assign last_beat = r_fire && (int'(beat) == block_words - 1);
    assign miss_base = {pc[31:offset_bits], {offset_bits{1'b0}}};

    // the burst code of the open refill tells which kind of block it is
    assign blk_sdram = (ar.burst == burst_incr);

    assign take_hit   = (state == st_lookup) && !redirect_valid && out_free && hit;
    assign start_miss = (state == st_lookup) && !redirect_valid && out_free && !hit;

    // a faulted block bypasses the cache unless fetch has moved elsewhere
    assign deliver_fault = (state == st_install) && blk_fault && !redirect_valid && !pend_valid;

    assign lookup_addr = pc;
    assign ar_valid    = (state == st_addr);
    assign r_ready     = (state == st_data);
    assign fill_valid  = (state == st_install) && !blk_fault;
    assign fill_addr   = {ar.addr[31:offset_bits], {offset_bits{1'b0}}};
    assign fill_data   = blk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_lookup;
            pc          <= reset_pc;
            fetch_valid <= 1'b0;
            pend_valid  <= 1'b0;
            blk_fault   <= 1'b0;
            beat        <= '0;
        end else begin
            case (state)
                st_lookup: begin
                    if (redirect_valid) begin
                        // whatever sits in the output register is wrong path now
                        pc          <= redirect.target;
                        fetch_valid <= 1'b0;
                    end else if (out_free) begin
                        fetch_valid <= hit;
                        if (hit) begin
                            pc <= pc + 32'd4;
                        end else begin
                            state     <= st_addr;
                            beat      <= '0;
                            blk_fault <= 1'b0;
                        end
                    end
                end
                st_addr: begin
                    if (ar_ready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (r.resp != resp_okay) begin
                            blk_fault <= 1'b1;
                        end
                        if (last_beat) begin
                            state <= st_install;
                        end else if (!blk_sdram) begin
                            // single-beat reads need a fresh address per word
                            state <= st_addr;
                        end
                    end
                end
                st_install: begin
                    state      <= st_lookup;
                    pend_valid <= 1'b0;
                    if (redirect_valid) begin
                        pc <= redirect.target;
                    end else if (pend_valid) begin
                        pc <= pend_target;
                    end else if (blk_fault) begin
                        fetch_valid <= 1'b1;
                        pc          <= pc + 32'd4;
                    end
                end
                default: begin
                    state <= st_lookup;
                end
            endcase

            // a redirect during a refill waits until the block is complete
            if (redirect_valid && (state == st_addr || state == st_data)) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_hit) begin
            fetch_pkt.pc    <= pc;
            fetch_pkt.inst  <= hit_word;
            fetch_pkt.fault <= 1'b0;
        end else if (deliver_fault) begin
            fetch_pkt.pc    <= pc;
            fetch_pkt.inst  <= blk[pc[offset_bits-1:2]];
            fetch_pkt.fault <= 1'b1;
        end

        if (start_miss) begin
            ar.addr <= miss_base;
            ar.id   <= '0;
            ar.size <= size_word;
            if (in_sdram(miss_base)) begin
                ar.len   <= 8'(block_words - 1);
                ar.burst <= burst_incr;
            end else begin
                ar.len   <= 8'd0;
                ar.burst <= burst_fixed;
            end
        end else if (r_fire && !last_beat && !blk_sdram) begin
            ar.addr <= ar.addr + 32'd4;
        end

        if (r_fire) begin
            blk[beat] <= r.data;
        end

        if (redirect_valid) begin
            pend_target <= redirect.target;
        end
    end

    // the slave may stall the address, but the request must not move meanwhile
    ar_hold_a: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    // an SDRAM burst closes on the same beat that fills the last word
    r_last_a: assert property (@(posedge clk) disable iff (rst)
        r_fire && blk_sdram |-> (r.last == (int'(beat) == block_words - 1)));

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // first instruction fetched after reset, at the start of SDRAM
    localparam logic [31:0] reset_pc = 32'ha000_0000;

    localparam int block_bytes = 16;
    localparam int block_words = block_bytes / 4;
    localparam int line_count  = 16;

    // address split is tag | index | offset
    localparam int offset_bits = $clog2(block_bytes);
    localparam int index_bits  = $clog2(line_count);
    localparam int tag_bits    = 32 - offset_bits - index_bits;

    // top nibble values of the SDRAM window
    localparam logic [3:0] sdram_hi_lo = 4'ha;
    localparam logic [3:0] sdram_hi_hi = 4'hb;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] target;
    } redirect_t;

    // word 0 of the block sits in the lowest bits
    typedef logic [block_words-1:0][31:0] block_t;

endpackage

/* hw/icache.sv */
`timescale 1ns/10ps

module icache (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       lookup_addr,
    output logic              hit,
    output logic [31:0]       hit_word,
    input  logic              fill_valid,
    input  logic [31:0]       fill_addr,
    input  fetch_pkg::block_t fill_data
);
    import fetch_pkg::*;

    logic [tag_bits-1:0]   tag_mem [line_count];
    block_t                data_mem [line_count];
    logic [line_count-1:0] valid;

    logic [index_bits-1:0] lk_index;
    logic [tag_bits-1:0]   lk_tag;
    logic [1:0]            lk_word;
    block_t                lk_block;

    logic [index_bits-1:0] fl_index;
    logic [tag_bits-1:0]   fl_tag;

    assign lk_index = lookup_addr[offset_bits +: index_bits];
    assign lk_tag   = lookup_addr[31 -: tag_bits];
    assign lk_word  = lookup_addr[offset_bits-1:2];

    assign fl_index = fill_addr[offset_bits +: index_bits];
    assign fl_tag   = fill_addr[31 -: tag_bits];

    // lookup is purely combinational so a hit can be registered on the next edge
    assign lk_block = data_mem[lk_index];
    assign hit      = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
    assign hit_word = lk_block[lk_word];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[fl_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fl_index]  <= fl_tag;
            data_mem[fl_index] <= fill_data;
        end
    end

    // the controller steps the read address through the block, the fill must not
    fill_align_a: assert property (@(posedge clk) disable iff (rst)
        fill_valid |-> (fill_addr[offset_bits-1:0] == '0));

endmodule

/* hw/ifetch_top.sv */
`timescale 1ns/10ps

module ifetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_valid,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  decode_ready,
    output logic                  fetch_valid,
    output fetch_pkg::fetch_pkt_t fetch_pkt,
    output logic                  ar_valid,
    output axi_pkg::ar_t          ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  axi_pkg::r_t           r,
    output logic                  r_ready
);
    import fetch_pkg::*;

    logic [31:0] lookup_addr;
    logic        hit;
    logic [31:0] hit_word;
    logic        fill_valid;
    logic [31:0] fill_addr;
    block_t      fill_data;

    fetch_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .decode_ready   (decode_ready),
        .fetch_valid    (fetch_valid),
        .fetch_pkt      (fetch_pkt),
        .lookup_addr    (lookup_addr),
        .hit            (hit),
        .hit_word       (hit_word),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_data      (fill_data),
        .ar_valid       (ar_valid),
        .ar             (ar),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r              (r),
        .r_ready        (r_ready)
    );

    icache cache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_word    (hit_word),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data)
    );

endmodule

/* ifetch.f */
hw/fetch_pkg.sv
hw/axi_pkg.sv
hw/icache.sv
hw/fetch_ctrl.sv
hw/ifetch_top.sv
test/ifetch_checker.sv
test/ifetch_tb.sv

/* test/ifetch_checker.sv */
`timescale 1ns/10ps

module ifetch_checker (
    input logic                  clk,
    input logic                  rst,
    input int                    phase,
    input logic                  redirect_valid,
    input fetch_pkg::redirect_t  redirect,
    input logic                  decode_ready,
    input logic                  fetch_valid,
    input fetch_pkg::fetch_pkt_t fetch_pkt,
    input logic                  ar_valid,
    input axi_pkg::ar_t          ar,
    input logic                  ar_ready,
    input logic                  r_valid,
    input axi_pkg::r_t           r,
    input logic                  r_ready
);
    import fetch_pkg::*;
    import axi_pkg::*;

    int error_count = 0;
    int pkt_count = 0;
    int ar_count = 0;
    int ar_fixed_count = 0;
    int redir_count = 0;
    int fault_pkt_count = 0;

    logic [31:0]           exp_pc;
    logic                  hold_valid;
    fetch_pkt_t            hold_pkt;
    logic [31:0]           fx_base;
    int                    fx_count;
    logic [line_count-1:0] model_valid;
    logic [tag_bits-1:0]   model_tag [line_count];
    logic [31:0]           rf_base;
    int                    rf_beats;
    logic                  rf_fault;
    logic                  fault_fresh;
    logic [31:0]           fault_block;
    int                    rd_open;

    int last_phase = 0;
    int pkt_mark = 0;
    int ar_mark = 0;
    int err_mark = 0;

    // memory contents seen by fetch, also used by the AXI slave in the testbench
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        return h ^ {h[15:0], h[31:16]};
    endfunction

    function automatic logic fault_addr(input logic [31:0] addr);
        return addr >= 32'hc000_0040;
    endfunction

    function automatic logic [31:0] block_of(input logic [31:0] addr);
        return {addr[31:offset_bits], {offset_bits{1'b0}}};
    endfunction

    function automatic string phase_name(input int p);
        case (p)
            1: return "sequential fetch";
            2: return "single-beat refills";
            3: return "cache hits";
            4: return "redirects";
            5: return "back-pressure";
            default: return "access faults";
        endcase
    endfunction

    task flag_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task check_transfer();
        if (hold_valid && (!fetch_valid || fetch_pkt !== hold_pkt))
            flag_error($sformatf("stalled output expected valid 1 pkt %h, got valid %b pkt %h",
                                 hold_pkt, fetch_valid, fetch_pkt));
        hold_valid = fetch_valid && !decode_ready && !redirect_valid;
        hold_pkt   = fetch_pkt;
        if (fetch_valid && decode_ready) begin
            if (fetch_pkt.pc !== exp_pc)
                flag_error($sformatf("pc expected %h, got %h", exp_pc, fetch_pkt.pc));
            if (fetch_pkt.inst !== mem_word(fetch_pkt.pc))
                flag_error($sformatf("inst at %h expected %h, got %h", fetch_pkt.pc,
                                     mem_word(fetch_pkt.pc), fetch_pkt.inst));
            if (fetch_pkt.fault !== fault_addr(fetch_pkt.pc))
                flag_error($sformatf("fault at %h expected %b, got %b", fetch_pkt.pc,
                                     fault_addr(fetch_pkt.pc), fetch_pkt.fault));
            if (fetch_pkt.fault) begin
                // every faulted packet needs its own refill since nothing was installed
                if (!fault_fresh || fault_block !== block_of(fetch_pkt.pc))
                    flag_error($sformatf("faulted pc %h expected a fresh refill, last was %h",
                                         fetch_pkt.pc, fault_block));
                fault_fresh = 1'b0;
                fault_pkt_count++;
            end
            pkt_count++;
            exp_pc = exp_pc + 32'd4;
        end
        if (redirect_valid) begin
            exp_pc = redirect.target;
            redir_count++;
        end
    endtask

    task check_ar();
        logic [31:0] base;
        logic        starts;
        base   = block_of(ar.addr);
        starts = 1'b0;
        ar_count++;
        if (ar.addr[31:28] == sdram_hi_lo || ar.addr[31:28] == sdram_hi_hi) begin
            if (ar.len !== 8'd3 || ar.burst !== burst_incr || ar.addr !== base)
                flag_error($sformatf("SDRAM AR expected %h len 3 INCR, got %h len %0d burst %0d",
                                     base, ar.addr, ar.len, ar.burst));
            starts = 1'b1;
        end else begin
            if (ar.len !== 8'd0 || ar.burst !== burst_fixed)
                flag_error($sformatf("AR at %h expected len 0 FIXED, got len %0d burst %0d",
                                     ar.addr, ar.len, ar.burst));
            if (fx_count == 0) begin
                fx_base = base;
                starts  = 1'b1;
            end
            if (ar.addr !== fx_base + 32'(4 * fx_count))
                flag_error($sformatf("single-beat AR expected %h, got %h",
                                     fx_base + 32'(4 * fx_count), ar.addr));
            fx_count = (fx_count + 1) % block_words;
            ar_fixed_count++;
        end
        if (ar.size !== size_word)
            flag_error($sformatf("AR size expected %0d, got %0d", size_word, ar.size));
        if (starts) begin
            if (model_valid[base[offset_bits +: index_bits]] &&
                model_tag[base[offset_bits +: index_bits]] == base[31 -: tag_bits])
                flag_error($sformatf("block %h expected to hit, got an AR", base));
            rf_base  = base;
            rf_beats = 0;
            rf_fault = 1'b0;
            if (fault_addr(base)) begin
                fault_fresh = 1'b1;
                fault_block = base;
            end
        end
    endtask

    // only one read may be open, and data is accepted only while one is
    task check_read_flow();
        if (ar_valid && rd_open != 0)
            flag_error($sformatf("ar_valid expected 0 with %0d beats open, got 1", rd_open));
        if (r_ready && rd_open == 0)
            flag_error("r_ready expected 0 with no read open, got 1");
    endtask

    always @(negedge clk) begin
        if (rst) begin
            exp_pc      = reset_pc;
            hold_valid  = 1'b0;
            fx_count    = 0;
            model_valid = '0;
            rf_beats    = 0;
            fault_fresh = 1'b0;
            fault_block = '0;
            rd_open     = 0;
        end else begin
            check_transfer();
            check_read_flow();
            if (ar_valid && ar_ready) begin
                check_ar();
                rd_open = int'(ar.len) + 1;
            end
            if (r_valid && r_ready) begin
                rd_open--;
                rf_beats++;
                if (r.resp != resp_okay) begin
                    rf_fault = 1'b1;
                end
                if (rf_beats == block_words && !rf_fault) begin
                    model_valid[rf_base[offset_bits +: index_bits]] = 1'b1;
                    model_tag[rf_base[offset_bits +: index_bits]]   = rf_base[31 -: tag_bits];
                end
            end
        end
    end

    always @(phase) begin
        if (last_phase >= 1) begin
            $display("phase %0d %s finished: %0d packets, %0d AR, %0d errors", last_phase,
                     phase_name(last_phase), pkt_count - pkt_mark, ar_count - ar_mark,
                     error_count - err_mark);
        end
        last_phase = phase;
        pkt_mark   = pkt_count;
        ar_mark    = ar_count;
        err_mark   = error_count;
    end

endmodule

/* test/ifetch_tb.sv */
`timescale 1ns/10ps

module ifetch_tb;
    import fetch_pkg::*;
    import axi_pkg::*;

    logic       clk;
    logic       rst;
    logic       redirect_valid;
    redirect_t  redirect;
    logic       decode_ready;
    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       ar_valid;
    ar_t        ar;
    logic       ar_ready;
    logic       r_valid;
    r_t         r;
    logic       r_ready;
    int         phase;

    int          ready_pct;
    int          redir_pm;
    int          redir_mode;
    logic        force_redir;
    logic [31:0] force_target;
    logic        run_stim;
    logic        timed_out;

    logic        ar_hs;
    logic        r_hs;
    ar_t         ar_seen;
    logic        rd_busy;
    logic [31:0] rd_addr;
    int          rd_left;

    ifetch_top dut_i (.*);
    ifetch_checker chk_i (.*);

    always #50 clk = ~clk;

    // small windows so that redirects keep landing in the same blocks
    function automatic logic [31:0] pick_target(input int mode);
        int sel;
        int word;
        sel  = $urandom % 3;
        word = $urandom % 16;
        if (mode == 1)
            return 32'hc000_0040 + 32'(word * 4);
        case (sel)
            0: return 32'ha000_0000 + 32'(word * 4);
            1: return 32'h1000_0040 + 32'(word * 4);
            default: return 32'hb000_0180 + 32'(word * 4);
        endcase
    endfunction

    function automatic int progress(input int which);
        case (which)
            0: return chk_i.pkt_count;
            1: return chk_i.ar_fixed_count;
            2: return chk_i.redir_count;
            default: return chk_i.fault_pkt_count;
        endcase
    endfunction

    task automatic start_phase(input int p, input int ready, input int pm, input int mode);
        phase      = p;
        ready_pct  = ready;
        redir_pm   = pm;
        redir_mode = mode;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        force_target = target;
        force_redir  = 1'b1;
    endtask

    task automatic run_until(input int which, input int target);
        int cycles;
        cycles = 0;
        while (progress(which) < target && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (progress(which) < target) begin
            timed_out = 1'b1;
            $display("timeout: phase %0d stopped at %0d of %0d after %0d cycles", phase,
                     progress(which), target, cycles);
        end
    endtask

    // AXI slave, decode back-pressure and redirects, all from one process
    always begin
        @(negedge clk);
        ar_hs   = ar_valid && ar_ready;
        r_hs    = r_valid && r_ready;
        ar_seen = ar;
        @(posedge clk);
        #1;
        if (!run_stim) begin
            ar_ready       = 1'b0;
            r_valid        = 1'b0;
            decode_ready   = 1'b0;
            redirect_valid = 1'b0;
            rd_busy        = 1'b0;
        end else begin
            if (r_hs) begin
                rd_addr = rd_addr + 32'd4;
                rd_left = rd_left - 1;
                rd_busy = (rd_left != 0);
            end
            if (ar_hs) begin
                rd_busy = 1'b1;
                rd_addr = ar_seen.addr;
                rd_left = int'(ar_seen.len) + 1;
            end
            // a raised r_valid stays until its handshake
            if (!r_valid || r_hs) begin
                r_valid = rd_busy && ($urandom % 100 < 75);
                r.data  = chk_i.mem_word(rd_addr);
                r.resp  = chk_i.fault_addr(rd_addr) ? 2'b10 : resp_okay;
                r.last  = (rd_left == 1);
                r.id    = '0;
            end
            ar_ready     = !rd_busy && ($urandom % 100 < 60);
            decode_ready = ($urandom % 100) < ready_pct;
            if (force_redir) begin
                redirect_valid  = 1'b1;
                redirect.target = force_target;
                force_redir     = 1'b0;
            end else begin
                redirect_valid  = ($urandom % 1000) < redir_pm;
                redirect.target = pick_target(redir_mode);
            end
        end
    end

    initial begin
        void'($urandom(2649));
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect       = '0;
        decode_ready   = 1'b0;
        ar_ready       = 1'b0;
        r_valid        = 1'b0;
        r              = '0;
        phase          = 0;
        force_redir    = 1'b0;
        force_target   = '0;
        run_stim       = 1'b0;
        timed_out      = 1'b0;
        start_phase(0, 100, 0, 0);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        run_stim = 1'b1;

        start_phase(1, 100, 0, 0);
        run_until(0, 40);
        if (!timed_out) begin
            start_phase(2, 100, 0, 0);
            redirect_to(32'h1000_00c0);
            run_until(1, chk_i.ar_fixed_count + 8);
        end
        if (!timed_out) begin
            // blocks of the first phase are still resident
            start_phase(3, 100, 0, 0);
            redirect_to(reset_pc);
            run_until(0, chk_i.pkt_count + 32);
        end
        if (!timed_out) begin
            start_phase(4, 100, 60, 0);
            run_until(2, chk_i.redir_count + 20);
        end
        if (!timed_out) begin
            start_phase(5, 50, 10, 0);
            run_until(0, chk_i.pkt_count + 60);
        end
        if (!timed_out) begin
            start_phase(6, 70, 20, 1);
            redirect_to(32'hc000_0040);
            run_until(3, chk_i.fault_pkt_count + 6);
        end
        if (!timed_out) begin
            phase = 7;
        end
        repeat (2) @(posedge clk);

        $display("closing: %0d packets, %0d AR, %0d redirects, %0d faulted, %0d errors",
                 chk_i.pkt_count, chk_i.ar_count, chk_i.redir_count,
                 chk_i.fault_pkt_count, chk_i.error_count);
        if (!timed_out && chk_i.error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
